//--- source/conv_pkg.sv
package conv_pkg;

	// datapath widths
	localparam int DATA_WIDTH = 16;
	localparam int ACC_WIDTH = 32;

	// engine limits
	localparam int PARA_KERNEL = 2; // kernels computed side by side
	localparam int FM_SIZE_MAX = 8;
	localparam int FM_DEPTH_MAX = 4;
	localparam int KERNEL_SIZE_MAX = 3;

	// storage sizes
	localparam int FM_WORDS = FM_DEPTH_MAX * FM_SIZE_MAX * FM_SIZE_MAX;
	localparam int W_WORDS = FM_DEPTH_MAX * KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;
	localparam int FIFO_DEPTH = 4;

	localparam int FM_ADDR_WIDTH = $clog2(FM_WORDS);
	localparam int W_ADDR_WIDTH = $clog2(W_WORDS);
	localparam int SIZE_WIDTH = $clog2(FM_SIZE_MAX + 1);
	localparam int KSIZE_WIDTH = $clog2(KERNEL_SIZE_MAX + 1);
	localparam int DEPTH_WIDTH = $clog2(FM_DEPTH_MAX + 1);
	localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	typedef logic signed [DATA_WIDTH-1:0] data_t; // pixel or weight
	typedef logic signed [ACC_WIDTH-1:0] acc_t;

	typedef logic [FM_ADDR_WIDTH-1:0] fm_addr_t; // slice*64 + row*8 + col
	typedef logic [W_ADDR_WIDTH-1:0] w_addr_t; // slice*9 + ky*3 + kx
	typedef logic [SIZE_WIDTH-1:0] size_t;
	typedef logic [KSIZE_WIDTH-1:0] ksize_t;
	typedef logic [DEPTH_WIDTH-1:0] depth_t;

	// kernel 0 in the low bits
	typedef logic [PARA_KERNEL*DATA_WIDTH-1:0] weight_vec_t;
	typedef logic [PARA_KERNEL*ACC_WIDTH-1:0] acc_vec_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DRAIN, // waiting for the last results to leave
		SEQ_DONE
	} seq_state_t;

endpackage

//--- source/fm_ram.sv
`timescale 1ns/1ns

module fm_ram (
	input  logic               clk,

	// load port
	input  logic               wr_en_i,
	input  conv_pkg::fm_addr_t wr_addr_i,
	input  conv_pkg::data_t    wr_data_i,

	// sequencer read port
	input  logic               rd_en_i,
	input  conv_pkg::fm_addr_t rd_addr_i,
	output conv_pkg::data_t    rd_data_o
);
	import conv_pkg::*;

	data_t mem_q [FM_WORDS];

	// one slice after another, rows of FM_SIZE_MAX pixels
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			mem_q[wr_addr_i] <= wr_data_i;
		end
	end

	// registered read, data one cycle after the enable
	always_ff @(posedge clk) begin
		if (rd_en_i) begin
			rd_data_o <= mem_q[rd_addr_i]; // old word on a same-cycle write
		end
	end

endmodule

//--- source/weight_ram.sv
`timescale 1ns/1ns

module weight_ram (
	input  logic                  clk,

	// load port, one tap of every kernel per word
	input  logic                  wr_en_i,
	input  conv_pkg::w_addr_t     wr_addr_i,
	input  conv_pkg::weight_vec_t wr_data_i,

	// sequencer read port
	input  logic                  rd_en_i,
	input  conv_pkg::w_addr_t     rd_addr_i,
	output conv_pkg::weight_vec_t rd_data_o
);
	import conv_pkg::*;

	// one bank per kernel, all on the same address
	for (genvar k = 0; k < PARA_KERNEL; k++) begin : g_bank
		data_t bank_q [W_WORDS];
		data_t rd_q;

		always_ff @(posedge clk) begin
			if (wr_en_i) begin
				bank_q[wr_addr_i] <= wr_data_i[k*DATA_WIDTH +: DATA_WIDTH];
			end
		end

		always_ff @(posedge clk) begin
			if (rd_en_i) begin
				rd_q <= bank_q[rd_addr_i];
			end
		end

		assign rd_data_o[k*DATA_WIDTH +: DATA_WIDTH] = rd_q; // kernel k slice
	end

endmodule

//--- source/window_sequencer.sv
`timescale 1ns/1ns

module window_sequencer (
	input  logic               clk,
	input  logic               rst,
	input  logic               fm_wr_valid_i,
	input  logic               w_wr_valid_i,
	input  logic               start_valid_i,
	input  conv_pkg::size_t    fm_size_i,
	input  conv_pkg::depth_t   fm_depth_i,
	input  conv_pkg::ksize_t   kernel_size_i,
	output logic               load_ready_o,
	output logic               start_ready_o,
	output logic               fm_rd_en_o, // also the weight read enable
	output conv_pkg::fm_addr_t fm_rd_addr_o,
	output conv_pkg::w_addr_t  w_rd_addr_o,
	output logic               tap_first_o,
	output logic               tap_last_o,
	input  logic               space_i,
	input  logic               fifo_empty_i, // fifo and MAC pipeline both empty
	output logic               layer_ready_o
);
	import conv_pkg::*;

	seq_state_t state_q;
	size_t size_q; // config latched on start
	depth_t depth_q;
	ksize_t ks_q;
	size_t row_q; // output position
	size_t col_q;
	depth_t slice_q;
	ksize_t ky_q; // tap inside the window
	ksize_t kx_q;

	size_t out_last;
	logic kx_end;
	logic ky_end;
	logic slice_end;
	logic col_end;
	logic row_end;
	logic at_first;
	logic at_last;
	logic start_fire;

	assign load_ready_o = (state_q == SEQ_IDLE) || (state_q == SEQ_DONE);
	// a pending load goes in before the run starts
	assign start_ready_o = load_ready_o && !fm_wr_valid_i && !w_wr_valid_i;
	assign start_fire = start_valid_i && start_ready_o;

	assign out_last = size_q - size_t'(ks_q); // last valid output coordinate
	assign kx_end = (kx_q == ks_q - 2'd1);
	assign ky_end = (ky_q == ks_q - 2'd1);
	assign slice_end = (slice_q == depth_q - 3'd1);
	assign col_end = (col_q == out_last);
	assign row_end = (row_q == out_last);
	assign at_first = (slice_q == '0) && (ky_q == '0) && (kx_q == '0);
	assign at_last = kx_end && ky_end && slice_end;

	// new position only with room for its result, mid-position reads never stall
	assign fm_rd_en_o = (state_q == SEQ_RUN) && (!at_first || space_i);
	assign tap_first_o = fm_rd_en_o && at_first;
	assign tap_last_o = fm_rd_en_o && at_last;

	assign fm_rd_addr_o = fm_addr_t'(slice_q * FM_SIZE_MAX * FM_SIZE_MAX
		+ (row_q + ky_q) * FM_SIZE_MAX + col_q + kx_q);
	assign w_rd_addr_o = w_addr_t'(slice_q * KERNEL_SIZE_MAX * KERNEL_SIZE_MAX
		+ ky_q * KERNEL_SIZE_MAX + kx_q);

	// high one cycle early in drain so it rises right after the last pop
	assign layer_ready_o = (state_q == SEQ_DONE) || ((state_q == SEQ_DRAIN) && fifo_empty_i);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state_q <= SEQ_IDLE;
			size_q <= '0;
			depth_q <= '0;
			ks_q <= '0;
			row_q <= '0;
			col_q <= '0;
			slice_q <= '0;
			ky_q <= '0;
			kx_q <= '0;
		end else begin
			case (state_q)
				SEQ_IDLE, SEQ_DONE: begin
					if (start_fire) begin
						state_q <= SEQ_RUN;
						size_q <= fm_size_i;
						depth_q <= fm_depth_i;
						ks_q <= kernel_size_i;
						row_q <= '0;
						col_q <= '0;
						slice_q <= '0;
						ky_q <= '0;
						kx_q <= '0;
					end
				end
				SEQ_RUN: begin
					if (fm_rd_en_o) begin
						kx_q <= kx_end ? '0 : kx_q + 2'd1;
						if (kx_end) begin
							ky_q <= ky_end ? '0 : ky_q + 2'd1;
						end
						if (kx_end && ky_end) begin
							slice_q <= slice_end ? '0 : slice_q + 3'd1;
						end
						if (at_last) begin // position done, step row-major
							col_q <= col_end ? '0 : col_q + 4'd1;
							if (col_end) begin
								row_q <= row_q + 4'd1;
							end
							if (col_end && row_end) begin
								state_q <= SEQ_DRAIN;
							end
						end
					end
				end
				SEQ_DRAIN: begin
					if (fifo_empty_i) begin
						state_q <= SEQ_DONE;
					end
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

endmodule

//--- source/mac_array.sv
`timescale 1ns/1ns

module mac_array (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rd_valid_i, // read issued this cycle
	input  logic                  tap_first_i,
	input  logic                  tap_last_i,
	input  conv_pkg::data_t       pixel_i,
	input  conv_pkg::weight_vec_t weights_i,
	output logic                  push_o,
	output conv_pkg::acc_vec_t    push_data_o,
	output logic                  busy_o
);
	import conv_pkg::*;

	// flags delayed to meet the RAM data
	logic valid_q;
	logic first_q;
	logic last_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			valid_q <= 1'b0;
			first_q <= 1'b0;
			last_q <= 1'b0;
			push_o <= 1'b0;
		end else begin
			valid_q <= rd_valid_i;
			first_q <= tap_first_i;
			last_q <= tap_last_i;
			push_o <= valid_q && last_q; // sums complete after the last tap
		end
	end

	// a position still in flight
	assign busy_o = valid_q || push_o;

	for (genvar lane = 0; lane < PARA_KERNEL; lane++) begin : g_lane
		data_t weight;
		acc_t prod;
		acc_t acc_q;

		assign weight = weights_i[lane*DATA_WIDTH +: DATA_WIDTH];
		assign prod = pixel_i * weight; // signed 16x16 into 32

		// wraps modulo 2^32
		always_ff @(posedge clk) begin
			if (valid_q) begin
				acc_q <= first_q ? prod : acc_q + prod;
			end
		end

		// held during the push cycle, next position loads at its end
		assign push_data_o[lane*ACC_WIDTH +: ACC_WIDTH] = acc_q;
	end

endmodule

//--- source/result_fifo.sv
`timescale 1ns/1ns

module result_fifo (
	input  logic               clk,
	input  logic               rst,
	input  logic               push_i,
	input  conv_pkg::acc_vec_t push_data_i,
	output logic               res_valid_o,
	input  logic               res_ready_i,
	output conv_pkg::acc_vec_t res_data_o,
	output logic               space_o,
	output logic               empty_o
);
	import conv_pkg::*;

	acc_vec_t mem_q [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
	logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
	logic [FIFO_CNT_WIDTH-1:0] count_q;
	logic [FIFO_CNT_WIDTH-1:0] free;
	logic pop;

	assign res_valid_o = (count_q != '0);
	assign empty_o = (count_q == '0);
	assign res_data_o = mem_q[rd_ptr_q];
	assign pop = res_valid_o && res_ready_i;

	// a push in flight already counts as taken
	assign free = FIFO_CNT_WIDTH'(FIFO_DEPTH) - count_q - FIFO_CNT_WIDTH'(push_i);
	// room for the position still in the MAC plus the next one
	assign space_o = (free >= FIFO_CNT_WIDTH'(2));

	always_ff @(posedge clk) begin
		if (push_i) begin
			mem_q[wr_ptr_q] <= push_data_i;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= wr_ptr_q + 1'b1; // depth is a power of two
			end
			if (pop) begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			count_q <= count_q + FIFO_CNT_WIDTH'(push_i) - FIFO_CNT_WIDTH'(pop);
		end
	end

endmodule

//--- source/conv_layer_top.sv
`timescale 1ns/1ns

module conv_layer_top (
	input  logic                  clk,
	input  logic                  rst,

	// feature map load
	input  logic                  fm_wr_valid_i,
	output logic                  fm_wr_ready_o,
	input  conv_pkg::fm_addr_t    fm_wr_addr_i,
	input  conv_pkg::data_t       fm_wr_data_i,

	// weight load
	input  logic                  w_wr_valid_i,
	output logic                  w_wr_ready_o,
	input  conv_pkg::w_addr_t     w_wr_addr_i,
	input  conv_pkg::weight_vec_t w_wr_data_i,

	// start with config
	input  logic                  start_valid_i,
	output logic                  start_ready_o,
	input  conv_pkg::size_t       fm_size_i,
	input  conv_pkg::depth_t      fm_depth_i,
	input  conv_pkg::ksize_t      kernel_size_i,

	// result stream
	output logic                  res_valid_o,
	input  logic                  res_ready_i,
	output conv_pkg::acc_vec_t    res_data_o,

	output logic                  layer_ready_o
);
	import conv_pkg::*;

	logic load_ready;
	logic rd_en;
	fm_addr_t fm_rd_addr;
	w_addr_t w_rd_addr;
	logic tap_first;
	logic tap_last;
	data_t pixel;
	weight_vec_t weights;
	logic push;
	acc_vec_t push_data;
	logic mac_busy;
	logic fifo_space;
	logic fifo_empty;

	assign fm_wr_ready_o = load_ready;
	assign w_wr_ready_o = load_ready;

	fm_ram u_fm_ram (
		.clk(clk), .wr_en_i(fm_wr_valid_i && load_ready), .wr_addr_i(fm_wr_addr_i),
		.wr_data_i(fm_wr_data_i), .rd_en_i(rd_en), .rd_addr_i(fm_rd_addr), .rd_data_o(pixel)
	);

	weight_ram u_weight_ram (
		.clk(clk), .wr_en_i(w_wr_valid_i && load_ready), .wr_addr_i(w_wr_addr_i),
		.wr_data_i(w_wr_data_i), .rd_en_i(rd_en), .rd_addr_i(w_rd_addr), .rd_data_o(weights)
	);

	// drain waits on the MAC pipeline as well as the fifo
	window_sequencer u_seq (
		.clk(clk), .rst(rst), .fm_wr_valid_i(fm_wr_valid_i), .w_wr_valid_i(w_wr_valid_i),
		.start_valid_i(start_valid_i), .fm_size_i(fm_size_i), .fm_depth_i(fm_depth_i),
		.kernel_size_i(kernel_size_i), .load_ready_o(load_ready), .start_ready_o(start_ready_o),
		.fm_rd_en_o(rd_en), .fm_rd_addr_o(fm_rd_addr), .w_rd_addr_o(w_rd_addr),
		.tap_first_o(tap_first), .tap_last_o(tap_last), .space_i(fifo_space),
		.fifo_empty_i(fifo_empty && !mac_busy), .layer_ready_o(layer_ready_o)
	);

	mac_array u_mac (
		.clk(clk), .rst(rst), .rd_valid_i(rd_en), .tap_first_i(tap_first), .tap_last_i(tap_last),
		.pixel_i(pixel), .weights_i(weights), .push_o(push), .push_data_o(push_data),
		.busy_o(mac_busy)
	);

	result_fifo u_fifo (
		.clk(clk), .rst(rst), .push_i(push), .push_data_i(push_data), .res_valid_o(res_valid_o),
		.res_ready_i(res_ready_i), .res_data_o(res_data_o), .space_o(fifo_space),
		.empty_o(fifo_empty)
	);

endmodule

//--- verification/conv_layer_assert.sv
`timescale 1ns/1ns

module conv_layer_assert (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  fm_wr_ready_i,
	input  logic                  w_wr_ready_i,
	input  logic                  start_valid_i,
	input  logic                  start_ready_i,
	input  logic                  res_valid_i,
	input  logic                  res_ready_i,
	input  conv_pkg::acc_vec_t    res_data_i,
	input  logic                  layer_ready_i
);

	logic run_q; // from a start transfer until completion

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			run_q <= 1'b0;
		end else if (start_valid_i && start_ready_i) begin
			run_q <= 1'b1;
		end else if (layer_ready_i) begin
			run_q <= 1'b0;
		end
	end

	// a stalled result stays put
	res_held: assert property (@(posedge clk) disable iff (!rst)
		res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_data_i))
		else $error("res_data_o changed while res_ready_i was low");

	// loads are shut out from start until done
	load_closed: assert property (@(posedge clk) disable iff (!rst)
		run_q && !layer_ready_i |-> !fm_wr_ready_i && !w_wr_ready_i)
		else $error("load ready high during a run");

	done_exclusive: assert property (@(posedge clk) disable iff (!rst)
		layer_ready_i |-> !res_valid_i)
		else $error("layer_ready_o high with a result pending");

	// first sample out of reset
	reset_values: assert property (@(posedge clk)
		$rose(rst) |-> !res_valid_i && !layer_ready_i && start_ready_i)
		else $error("wrong output values right after reset");

endmodule

bind conv_layer_top conv_layer_assert u_assert (
	.clk(clk), .rst(rst), .fm_wr_ready_i(fm_wr_ready_o), .w_wr_ready_i(w_wr_ready_o),
	.start_valid_i(start_valid_i), .start_ready_i(start_ready_o), .res_valid_i(res_valid_o),
	.res_ready_i(res_ready_i), .res_data_i(res_data_o), .layer_ready_i(layer_ready_o)
);

//--- verification/conv_layer_tb.sv
`timescale 1ns/1ns

module conv_layer_tb;
	import conv_pkg::*;

	// fm and weight writes over all tests
	localparam int LOAD_CYCLES = 64 + 9 + 192 + 27 + 18;
	// taps per run, the back-pressure run counted twice
	localparam int RUN_CYCLES = 16 * 1 + 16 * 27 + 16 * 27 * 2 + 49 * 8;
	localparam int WATCHDOG_NS = (LOAD_CYCLES + RUN_CYCLES + 100) * 4 * 10;

	logic clk = 1'b0;
	logic rst;
	logic fm_wr_valid_i, fm_wr_ready_o;
	fm_addr_t fm_wr_addr_i;
	data_t fm_wr_data_i;
	logic w_wr_valid_i, w_wr_ready_o;
	w_addr_t w_wr_addr_i;
	weight_vec_t w_wr_data_i;
	logic start_valid_i, start_ready_o;
	size_t fm_size_i;
	depth_t fm_depth_i;
	ksize_t kernel_size_i;
	logic res_valid_o, res_ready_i;
	acc_vec_t res_data_o;
	logic layer_ready_o;

	logic [31:0] lfsr_q = 32'h4a4e37cd;
	data_t fm_model [FM_WORDS]; // own copy of the loaded data
	data_t w_model [PARA_KERNEL][W_WORDS];
	int error_count = 0;
	int check_count = 0;

	always #5 clk = ~clk;

	conv_layer_top dut0 (.*);

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the DUT stopped making progress");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic data_t rand_value();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b = {b[6:0], next_bit()};
		end
		return {{8{b[7]}}, b}; // 8-bit signed range
	endfunction

	function automatic acc_t ref_sum(input int k, input int row, input int col,
			input int depth, input int ks);
		acc_t sum;
		sum = '0;
		for (int s = 0; s < depth; s++) begin
			for (int ky = 0; ky < ks; ky++) begin
				for (int kx = 0; kx < ks; kx++) begin
					sum += acc_t'(fm_model[s * 64 + (row + ky) * 8 + col + kx])
						* acc_t'(w_model[k][s * 9 + ky * 3 + kx]);
				end
			end
		end
		return sum;
	endfunction

	task automatic check_flag(input string name, input logic expected, input logic actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic write_fm(input fm_addr_t addr, input data_t data);
		fm_wr_valid_i = 1'b1;
		fm_wr_addr_i = addr;
		fm_wr_data_i = data;
		@(posedge clk);
		while (!fm_wr_ready_o) @(posedge clk);
		#1 fm_wr_valid_i = 1'b0;
	endtask

	task automatic write_weights(input w_addr_t addr, input weight_vec_t data);
		w_wr_valid_i = 1'b1;
		w_wr_addr_i = addr;
		w_wr_data_i = data;
		@(posedge clk);
		while (!w_wr_ready_o) @(posedge clk);
		#1 w_wr_valid_i = 1'b0;
	endtask

	// always the full 8x8 slice
	task automatic load_fm_random(input int depth);
		int addr;
		for (int s = 0; s < depth; s++) begin
			for (int p = 0; p < 64; p++) begin
				addr = s * 64 + p;
				fm_model[addr] = rand_value();
				write_fm(fm_addr_t'(addr), fm_model[addr]);
			end
		end
	endtask

	task automatic load_weights_random(input int depth);
		weight_vec_t vec;
		int addr;
		for (int s = 0; s < depth; s++) begin
			for (int t = 0; t < 9; t++) begin
				addr = s * 9 + t;
				for (int k = 0; k < PARA_KERNEL; k++) begin
					w_model[k][addr] = rand_value();
					vec[k * DATA_WIDTH +: DATA_WIDTH] = w_model[k][addr];
				end
				write_weights(w_addr_t'(addr), vec);
			end
		end
	endtask

	task automatic start_run(input int size, input int depth, input int ks);
		start_valid_i = 1'b1;
		fm_size_i = size_t'(size);
		fm_depth_i = depth_t'(depth);
		kernel_size_i = ksize_t'(ks);
		@(posedge clk);
		while (!start_ready_o) @(posedge clk);
		#1 start_valid_i = 1'b0;
	endtask

	task automatic run_and_check(input int size, input int depth, input int ks, input bit bp);
		acc_vec_t exp_q [$];
		acc_vec_t exp_vec;
		int n_out;
		int got;
		int cycle;
		int hold;
		n_out = size - ks + 1;
		// consumer idle long enough to fill the fifo and stall the sequencer
		hold = bp ? (FIFO_DEPTH + 1) * depth * ks * ks + 10 : 0;
		for (int r = 0; r < n_out; r++) begin
			for (int c = 0; c < n_out; c++) begin // row-major
				for (int k = 0; k < PARA_KERNEL; k++) begin
					exp_vec[k * ACC_WIDTH +: ACC_WIDTH] = ref_sum(k, r, c, depth, ks);
				end
				exp_q.push_back(exp_vec);
			end
		end
		start_run(size, depth, ks);
		got = 0;
		cycle = 0;
		while (got < exp_q.size()) begin
			if (!bp) begin
				res_ready_i = 1'b1;
			end else if (cycle < hold) begin
				res_ready_i = 1'b0;
			end else begin
				res_ready_i = next_bit();
			end
			@(posedge clk);
			check_flag("fm_wr_ready_o", 1'b0, fm_wr_ready_o);
			check_flag("w_wr_ready_o", 1'b0, w_wr_ready_o);
			check_flag("layer_ready_o", 1'b0, layer_ready_o);
			if (res_valid_o && res_ready_i) begin
				exp_vec = exp_q[got];
				for (int k = 0; k < PARA_KERNEL; k++) begin
					check_count++;
					if (res_data_o[k * ACC_WIDTH +: ACC_WIDTH] !== exp_vec[k * ACC_WIDTH +: ACC_WIDTH]) begin
						error_count++;
						$display("Error res_data_o kernel %0d result %0d expected %h got %h", k, got,
							exp_vec[k * ACC_WIDTH +: ACC_WIDTH], res_data_o[k * ACC_WIDTH +: ACC_WIDTH]);
					end
				end
				got++;
			end
			cycle++;
			#1;
		end
		res_ready_i = 1'b1;
		// done one cycle after the last pop, and nothing extra behind it
		repeat (3) begin
			@(posedge clk);
			check_flag("layer_ready_o", 1'b1, layer_ready_o);
			check_flag("res_valid_o", 1'b0, res_valid_o);
			#1;
		end
	endtask

	task automatic test_reset_state();
		@(posedge clk);
		check_flag("res_valid_o", 1'b0, res_valid_o);
		check_flag("layer_ready_o", 1'b0, layer_ready_o);
		check_flag("fm_wr_ready_o", 1'b1, fm_wr_ready_o);
		check_flag("w_wr_ready_o", 1'b1, w_wr_ready_o);
		check_flag("start_ready_o", 1'b1, start_ready_o);
		#1;
	endtask

	task automatic test_pointwise();
		load_fm_random(1);
		load_weights_random(1);
		run_and_check(4, 1, 1, 1'b0);
	endtask

	task automatic test_full_window();
		load_fm_random(3);
		load_weights_random(3);
		run_and_check(6, 3, 3, 1'b0);
	endtask

	task automatic test_back_pressure();
		run_and_check(6, 3, 3, 1'b1); // same data as the full window run
	endtask

	task automatic test_reuse();
		load_weights_random(2);
		@(posedge clk);
		check_flag("layer_ready_o", 1'b1, layer_ready_o); // still set from the last run
		#1;
		run_and_check(8, 2, 2, 1'b0);
	endtask

	initial begin
		rst = 1'b0;
		fm_wr_valid_i = 1'b0;
		fm_wr_addr_i = '0;
		fm_wr_data_i = '0;
		w_wr_valid_i = 1'b0;
		w_wr_addr_i = '0;
		w_wr_data_i = '0;
		start_valid_i = 1'b0;
		fm_size_i = '0;
		fm_depth_i = '0;
		kernel_size_i = '0;
		res_ready_i = 1'b1;
		repeat (8) @(posedge clk);
		#1 rst = 1'b1;
		test_reset_state();
		test_pointwise();
		test_full_window();
		test_back_pressure();
		test_reuse();
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- conv_layer_top.f
source/conv_pkg.sv
source/fm_ram.sv
source/weight_ram.sv
source/window_sequencer.sv
source/mac_array.sv
source/result_fifo.sv
source/conv_layer_top.sv
verification/conv_layer_assert.sv
verification/conv_layer_tb.sv
